// File: files.f
src/decode_pkg.sv
src/handshake_reg.sv
src/control_unit.sv
src/extend.sv
src/regfile.sv
src/ctrl_regfile.sv
src/instr_decode.sv
src/decode_stage.sv
verification/decode_stage_checker.sv
verification/decode_stage_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = decode_stage_tb
FILE_LIST = files.f

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: verification/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

    localparam int total_instrs = 80;  // 8 + 20 + 16 + 6 + 30
    localparam int cycle_limit = 40 * total_instrs;

    logic clk = 1'b0;
    logic arst_n;
    logic in_req;
    logic in_ack;
    decode_pkg::fetch_t in_data;
    logic out_req;
    logic out_ack;
    decode_pkg::decode_t out_data;
    logic wb_we;
    logic [decode_pkg::reg_addr_w-1:0] wb_rd;
    logic [decode_pkg::xlen-1:0] wb_data;

    logic [31:0] rng = 32'he41921c1;
    logic [31:0] delay_rng = 32'he41921c1;
    logic [31:0] shadow_regs [32];
    logic [31:0] shadow_ctrl [decode_pkg::n_ctrl_regs];
    decode_pkg::decode_t exp_q [$];
    string name_q [$];
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int accepted = 0;
    int delivered = 0;
    int cycles = 0;

    always #2 clk = ~clk;

    decode_stage i_decode_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [2:0] alu_ref(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000: return sub ? 3'b001 : 3'b000;
            3'b001: return 3'b110;
            3'b010, 3'b011: return 3'b101;
            3'b100: return 3'b100;
            3'b101: return 3'b111;
            3'b110: return 3'b011;
            default: return 3'b010;
        endcase
    endfunction

    // builds the expected record and updates the control register shadow
    function automatic decode_pkg::decode_t decode_ref(input decode_pkg::fetch_t f);
        decode_pkg::decode_t d;
        logic [31:0] ins;
        logic [6:0] op;
        logic [1:0] a;
        ins = f.instr;
        op = ins[6:0];
        d = '0;
        d.pc = f.pc;
        d.pc_plus4 = f.pc_plus4;
        d.rs1 = ins[19:15];
        d.rs2 = ins[24:20];
        d.rd = ins[11:7];
        d.rd1 = (d.rs1 == 5'd0) ? 32'd0 : shadow_regs[d.rs1];
        d.rd2 = (d.rs2 == 5'd0) ? 32'd0 : shadow_regs[d.rs2];
        if (op == decode_pkg::op_store) begin
            d.imm_ext = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        end else if (op == decode_pkg::op_branch) begin
            d.imm_ext = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end else if (op == decode_pkg::op_jal) begin
            d.imm_ext = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end else begin
            d.imm_ext = {{20{ins[31]}}, ins[31:20]};
        end
        case (op)
            decode_pkg::op_load: {d.ctrl.reg_write, d.ctrl.result_src, d.ctrl.alu_src} = 4'b1011;
            decode_pkg::op_store: {d.ctrl.mem_write, d.ctrl.alu_src} = 2'b11;
            decode_pkg::op_op: d.ctrl.reg_write = 1'b1;
            decode_pkg::op_op_imm: {d.ctrl.reg_write, d.ctrl.alu_src} = 2'b11;
            decode_pkg::op_branch: begin
                d.ctrl.branch = 1'b1;
                d.ctrl.alu_control = 3'b001;  // subtract to compare
            end
            decode_pkg::op_jal: begin
                {d.ctrl.reg_write, d.ctrl.result_src, d.ctrl.jump} = 4'b1101;
            end
            decode_pkg::op_lui: {d.ctrl.reg_write, d.ctrl.result_src, d.ctrl.alu_src} = 4'b1111;
            decode_pkg::op_custom0: {d.ctrl.ctrl_write, d.ctrl.ctrl_src} = {1'b1, ins[12]};
            default: ;
        endcase
        if (op == decode_pkg::op_op || op == decode_pkg::op_op_imm) begin
            d.ctrl.alu_control = alu_ref(ins[14:12], op == decode_pkg::op_op && ins[30]);
        end
        a = d.imm_ext[1:0];
        d.ctrl_data = shadow_ctrl[a];
        for (int k = 0; k < decode_pkg::n_ctrl_regs; k++) begin
            d.status[k] = (shadow_ctrl[k] != 32'd0);
        end
        if (d.ctrl.ctrl_write) begin
            shadow_ctrl[a] = d.ctrl.ctrl_src ? {27'd0, d.rs1} : d.rd1;
        end
        return d;
    endfunction

    // random word with opcode and funct fields forced
    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] f3,
                                               input logic f7_5);
        logic [31:0] w;
        w = next_rand();
        w[6:0] = op;
        w[14:12] = f3;
        w[30] = f7_5;
        return w;
    endfunction

    function automatic decode_pkg::fetch_t fetch_of(input logic [31:0] instr);
        decode_pkg::fetch_t f;
        f.pc = next_rand();
        f.pc[1:0] = 2'b00;
        f.pc_plus4 = f.pc + 32'd4;
        f.instr = instr;
        return f;
    endfunction

    task automatic send_fetch(input logic [31:0] instr, input string name);
        decode_pkg::fetch_t f;
        f = fetch_of(instr);
        exp_q.push_back(decode_ref(f));
        name_q.push_back(name);
        @(negedge clk);
        in_data <= f;
        in_req <= 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req <= 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    // write lands at the second falling edge
    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        @(negedge clk);
        wb_we <= 1'b1;
        wb_rd <= rd;
        wb_data <= data;
        @(negedge clk);
        wb_we <= 1'b0;
        if (rd != 5'd0) shadow_regs[rd] = data;
    endtask

    task automatic end_test(input string name, input int err_start);
        while (exp_q.size() != 0 || out_ack) @(negedge clk);
        if (errors == err_start) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_start);
        end
    endtask

    // compare each record at out_req and ack it after a random delay
    initial begin
        decode_pkg::decode_t exp;
        string name;
        forever begin
            @(negedge clk);
            if (out_req) begin
                if (exp_q.size() == 0) begin
                    $display("Output record arrived with no instruction pending");
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    name = name_q.pop_front();
                    if (out_data !== exp) begin
                        $display("Mismatch in %s: expected %h, actual %h", name, exp, out_data);
                        errors++;
                    end
                end
                delay_rng = xorshift(delay_rng);
                repeat (delay_rng[1:0]) @(negedge clk);
                out_ack <= 1'b1;
                delivered++;
                do @(negedge clk); while (out_req);
                out_ack <= 1'b0;
            end
        end
    end

    // two records in flight at most
    initial begin
        logic ack_prev;
        ack_prev = 1'b0;
        forever begin
            @(negedge clk);
            if (in_ack && !ack_prev) begin
                if (accepted - delivered >= 2) begin
                    $display("in_ack was raised while both slots were full");
                    errors++;
                end
                accepted++;
            end
            ack_prev = in_ack;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [4:0] idx [8];
        logic [6:0] ops [8];
        logic [31:0] w;
        int e;
        arst_n = 1'b0;
        in_req = 1'b0;
        in_data = '0;
        out_ack = 1'b0;
        wb_we = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        for (int i = 0; i < 32; i++) shadow_regs[i] = 32'd0;
        for (int i = 0; i < decode_pkg::n_ctrl_regs; i++) shadow_ctrl[i] = 32'd0;
        repeat (2) @(negedge clk);
        arst_n <= 1'b1;

        e = errors;
        idx[0] = 5'd0;  // x0 write must be ignored
        for (int i = 1; i < 8; i++) idx[i] = 5'(next_rand() % 31 + 1);
        for (int i = 0; i < 8; i++) write_reg(idx[i], next_rand() | 32'd1);
        for (int i = 0; i < 8; i++) begin
            w = make_instr(decode_pkg::op_op, 3'b000, 1'b0);
            w[19:15] = idx[i];
            w[24:20] = idx[(i + 3) % 8];
            send_fetch(w, "writeback_read");
        end
        end_test("writeback_read", e);

        e = errors;
        send_fetch(make_instr(decode_pkg::op_lui, 3'b000, 1'b0), "control_words");
        send_fetch(make_instr(decode_pkg::op_jal, 3'b000, 1'b0), "control_words");
        send_fetch(make_instr(decode_pkg::op_load, 3'b010, 1'b0), "control_words");
        send_fetch(make_instr(decode_pkg::op_store, 3'b010, 1'b0), "control_words");
        send_fetch(make_instr(decode_pkg::op_branch, 3'b000, 1'b0), "control_words");
        send_fetch(make_instr(decode_pkg::op_op, 3'b000, 1'b1), "control_words");
        send_fetch(make_instr(decode_pkg::op_op_imm, 3'b000, 1'b1), "control_words");
        for (int f3 = 0; f3 < 8; f3++) begin
            send_fetch(make_instr(decode_pkg::op_op, 3'(f3), 1'b0), "control_words");
        end
        for (int f3 = 1; f3 < 6; f3 += 2) begin
            send_fetch(make_instr(decode_pkg::op_op_imm, 3'(f3), 1'b0), "control_words");
        end
        send_fetch(make_instr(decode_pkg::op_custom0, 3'b000, 1'b0), "control_words");
        send_fetch(make_instr(7'b1111111, 3'b000, 1'b1), "control_words");  // unknown
        end_test("control_words", e);

        e = errors;
        ops[0] = decode_pkg::op_load;
        ops[1] = decode_pkg::op_store;
        ops[2] = decode_pkg::op_branch;
        ops[3] = decode_pkg::op_jal;
        for (int i = 0; i < 16; i++) begin
            w = next_rand();
            w[6:0] = ops[i % 4];
            send_fetch(w, "immediates");
        end
        end_test("immediates", e);

        e = errors;
        write_reg(5'd5, next_rand() | 32'd1);
        send_fetch({12'd1, 5'd5, 3'b000, 5'd0, decode_pkg::op_custom0}, "ctrl_regs");
        send_fetch({12'd2, 5'd19, 3'b001, 5'd0, decode_pkg::op_custom0}, "ctrl_regs");
        send_fetch({12'd1, 5'd0, 3'b000, 5'd1, decode_pkg::op_op_imm}, "ctrl_regs");
        send_fetch({12'd2, 5'd0, 3'b000, 5'd1, decode_pkg::op_op_imm}, "ctrl_regs");
        send_fetch({12'd1, 5'd0, 3'b000, 5'd0, decode_pkg::op_custom0}, "ctrl_regs");
        send_fetch({12'd1, 5'd0, 3'b000, 5'd1, decode_pkg::op_op_imm}, "ctrl_regs");
        end_test("ctrl_regs", e);

        e = errors;
        ops[4] = decode_pkg::op_op;
        ops[5] = decode_pkg::op_op_imm;
        ops[6] = decode_pkg::op_lui;
        ops[7] = decode_pkg::op_custom0;
        for (int i = 0; i < 30; i++) begin
            w = next_rand();
            w[6:0] = ops[next_rand() % 8];
            send_fetch(w, "burst");
        end
        end_test("burst", e);

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verification/decode_stage_checker.sv
`timescale 1ns/10ps

module decode_stage_checker (
    input logic                clk,
    input logic                arst_n,
    input logic                in_req,
    input logic                in_ack,
    input logic                out_req,
    input logic                out_ack,
    input decode_pkg::decode_t out_data
);
    // ack only answers a pending request
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

    assert property (@(posedge clk) disable iff (!arst_n)
        (out_req && !out_ack) |=> $stable(out_data))
        else $error("out_data changed while waiting for out_ack");

    // return to zero before the next request
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose while out_ack was high");

    assert property (@(posedge clk)
        !arst_n |-> (!in_ack && !out_req))
        else $error("handshake outputs active during reset");

endmodule

bind decode_stage decode_stage_checker i_decode_stage_checker (.*);

// File: src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_req,
    output logic                              in_ack,
    input  decode_pkg::fetch_t                in_data,
    output logic                              out_req,
    input  logic                              out_ack,
    output decode_pkg::decode_t               out_data,
    input  logic                              wb_we,
    input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [decode_pkg::xlen-1:0]       wb_data
);
    logic a_req;
    logic b_ack;
    logic accept;
    decode_pkg::fetch_t a_data;
    decode_pkg::decode_t dec;

    handshake_reg #(
        .payload_t (decode_pkg::fetch_t)
    ) slot_a (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_data  (in_data),
        .out_req  (a_req),
        .out_ack  (b_ack),
        .out_data (a_data)
    );

    // b has just acked while a still holds the record, true one cycle per transfer
    assign accept = a_req & b_ack;

    instr_decode i_instr_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .fetch   (a_data),
        .accept  (accept),
        .wb_we   (wb_we),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .dec     (dec)
    );

    handshake_reg #(
        .payload_t (decode_pkg::decode_t)
    ) slot_b (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (a_req),
        .in_ack   (b_ack),
        .in_data  (dec),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

endmodule

// File: src/instr_decode.sv
`timescale 1ns/10ps

module instr_decode (
    input  logic                              clk,
    input  logic                              arst_n,
    input  decode_pkg::fetch_t                fetch,
    input  logic                              accept,
    input  logic                              wb_we,
    input  logic [decode_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [decode_pkg::xlen-1:0]       wb_data,
    output decode_pkg::decode_t               dec
);
    decode_pkg::ctrl_t ctrl;
    logic [1:0] imm_src;
    logic [decode_pkg::xlen-1:0] rd1;
    logic [decode_pkg::xlen-1:0] rd2;
    logic [decode_pkg::xlen-1:0] imm_ext;
    logic [decode_pkg::reg_addr_w-1:0] rs1;
    logic [decode_pkg::reg_addr_w-1:0] rs2;
    logic [decode_pkg::reg_addr_w-1:0] rd;
    logic [decode_pkg::xlen-1:0] ctrl_din;
    logic [decode_pkg::xlen-1:0] ctrl_dout;
    logic [decode_pkg::n_ctrl_regs-1:0] status;
    logic ctrl_we;

    assign rs1 = fetch.instr[19:15];
    assign rs2 = fetch.instr[24:20];
    assign rd = fetch.instr[11:7];

    control_unit i_control_unit (
        .instr   (fetch.instr),
        .ctrl    (ctrl),
        .imm_src (imm_src)
    );

    regfile i_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (wb_we),
        .a1     (rs1),
        .a2     (rs2),
        .a3     (wb_rd),
        .wd     (wb_data),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    extend i_extend (
        .instr   (fetch.instr[31:7]),
        .imm_src (imm_src),
        .imm_ext (imm_ext)
    );

    // zero-extended rs1 field or rd1
    assign ctrl_din = ctrl.ctrl_src ? {{(decode_pkg::xlen - decode_pkg::reg_addr_w){1'b0}}, rs1}
                                    : rd1;
    assign ctrl_we = accept & ctrl.ctrl_write;  // once per transfer

    ctrl_regfile i_ctrl_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (ctrl_we),
        .addr   (imm_ext[decode_pkg::ctrl_addr_w-1:0]),
        .din    (ctrl_din),
        .dout   (ctrl_dout),
        .status (status)
    );

    always_comb begin
        dec.ctrl = ctrl;
        dec.pc = fetch.pc;
        dec.pc_plus4 = fetch.pc_plus4;
        dec.rd1 = rd1;
        dec.rd2 = rd2;
        dec.imm_ext = imm_ext;
        dec.rs1 = rs1;
        dec.rs2 = rs2;
        dec.rd = rd;
        dec.ctrl_data = ctrl_dout;  // value before this instruction's write
        dec.status = status;
    end

endmodule

// File: src/ctrl_regfile.sv
`timescale 1ns/10ps

module ctrl_regfile (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               we,
    input  logic [decode_pkg::ctrl_addr_w-1:0] addr,
    input  logic [decode_pkg::xlen-1:0]        din,
    output logic [decode_pkg::xlen-1:0]        dout,
    output logic [decode_pkg::n_ctrl_regs-1:0] status
);
    logic [decode_pkg::xlen-1:0] cregs [decode_pkg::n_ctrl_regs];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < decode_pkg::n_ctrl_regs; i++) begin
                cregs[i] <= '0;
            end
        end else if (we) begin
            cregs[addr] <= din;
        end
    end

    assign dout = cregs[addr];

    // nonzero flag per register
    always_comb begin
        for (int k = 0; k < decode_pkg::n_ctrl_regs; k++) begin
            status[k] = |cregs[k];
        end
    end

endmodule

// File: src/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              we,
    input  logic [decode_pkg::reg_addr_w-1:0] a1,
    input  logic [decode_pkg::reg_addr_w-1:0] a2,
    input  logic [decode_pkg::reg_addr_w-1:0] a3,
    input  logic [decode_pkg::xlen-1:0]       wd,
    output logic [decode_pkg::xlen-1:0]       rd1,
    output logic [decode_pkg::xlen-1:0]       rd2
);
    logic [decode_pkg::xlen-1:0] regs [1:31];  // x0 not stored

    // write on falling edge, read in second half
    always_ff @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && a3 != '0) begin
            regs[a3] <= wd;
        end
    end

    assign rd1 = (a1 == '0) ? '0 : regs[a1];
    assign rd2 = (a2 == '0) ? '0 : regs[a2];

endmodule

// File: src/extend.sv
`timescale 1ns/10ps

module extend (
    input  logic [31:7]                 instr,
    input  logic [1:0]                  imm_src,
    output logic [decode_pkg::xlen-1:0] imm_ext
);
    always_comb begin
        case (imm_src)
            decode_pkg::imm_i: begin
                imm_ext = {{20{instr[31]}}, instr[31:20]};
            end
            decode_pkg::imm_s: begin
                imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            decode_pkg::imm_b: begin
                imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                // jal
                imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
        endcase
    end

endmodule

// File: src/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic [decode_pkg::xlen-1:0] instr,
    output decode_pkg::ctrl_t           ctrl,
    output logic [1:0]                  imm_src
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7_5;
    logic [1:0] alu_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7_5 = instr[30];

    // main decoder
    always_comb begin
        ctrl = '0;
        imm_src = decode_pkg::imm_i;
        alu_op = 2'b00;
        case (opcode)
            decode_pkg::op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.result_src = 2'b01;
                ctrl.alu_src = 1'b1;
            end
            decode_pkg::op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src = 1'b1;
                imm_src = decode_pkg::imm_s;
            end
            decode_pkg::op_op: begin
                ctrl.reg_write = 1'b1;
                alu_op = 2'b10;
            end
            decode_pkg::op_op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src = 1'b1;
                alu_op = 2'b10;
            end
            decode_pkg::op_branch: begin
                ctrl.branch = 1'b1;
                imm_src = decode_pkg::imm_b;
                alu_op = 2'b01;   // compare by subtraction
            end
            decode_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.result_src = 2'b10;
                ctrl.jump = 1'b1;
                imm_src = decode_pkg::imm_j;
            end
            decode_pkg::op_lui: begin
                // no U format here, execute forms the upper value
                ctrl.reg_write = 1'b1;
                ctrl.result_src = 2'b11;
                ctrl.alu_src = 1'b1;
            end
            decode_pkg::op_custom0: begin
                ctrl.ctrl_write = 1'b1;
                ctrl.ctrl_src = funct3[0];
            end
            default: ;
        endcase

        // alu decoder
        case (alu_op)
            2'b00: ctrl.alu_control = 3'b000;
            2'b01: ctrl.alu_control = 3'b001;
            default: begin
                case (funct3)
                    3'b000: begin
                        // sub only for register-register ops
                        if (opcode == decode_pkg::op_op && funct7_5) begin
                            ctrl.alu_control = 3'b001;
                        end else begin
                            ctrl.alu_control = 3'b000;
                        end
                    end
                    3'b001: ctrl.alu_control = 3'b110;  // sll
                    3'b010: ctrl.alu_control = 3'b101;  // slt
                    3'b011: ctrl.alu_control = 3'b101;
                    3'b100: ctrl.alu_control = 3'b100;  // xor
                    3'b101: ctrl.alu_control = 3'b111;  // srl
                    3'b110: ctrl.alu_control = 3'b011;  // or
                    default: ctrl.alu_control = 3'b010; // and
                endcase
            end
        endcase
    end

endmodule

// File: src/handshake_reg.sv
`timescale 1ns/10ps

module handshake_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_req,
    output logic     in_ack,
    input  payload_t in_data,
    output logic     out_req,
    input  logic     out_ack,
    output payload_t out_data
);
    logic full;
    logic out_wait;  // ack seen, waiting for it to return low
    logic capture;
    logic drain;
    payload_t data_q;

    assign capture = in_req & ~in_ack & ~full;
    assign drain = out_req & out_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
            in_ack <= 1'b0;
            out_wait <= 1'b0;
        end else begin
            if (capture) begin
                full <= 1'b1;
            end else if (drain) begin
                full <= 1'b0;
            end

            if (capture) begin
                in_ack <= 1'b1;
            end else if (!in_req) begin
                in_ack <= 1'b0;  // return to zero
            end

            if (drain) begin
                out_wait <= 1'b1;
            end else if (!out_ack) begin
                out_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) data_q <= in_data;
    end

    assign out_req = full & ~out_wait;
    assign out_data = data_q;

endmodule

// File: src/decode_pkg.sv
package decode_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // opcodes
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_custom0 = 7'b0001011;  // control register write

    // immediate formats
    localparam logic [1:0] imm_i = 2'b00;
    localparam logic [1:0] imm_s = 2'b01;
    localparam logic [1:0] imm_b = 2'b10;
    localparam logic [1:0] imm_j = 2'b11;

    localparam int n_ctrl_regs = 4;
    localparam int ctrl_addr_w = $clog2(n_ctrl_regs);

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] instr;
    } fetch_t;

    typedef struct packed {
        logic reg_write;
        logic [1:0] result_src;  // 00 alu, 01 mem, 10 pc+4, 11 imm
        logic mem_write;
        logic jump;
        logic branch;
        logic alu_src;
        logic [2:0] alu_control;
        logic ctrl_write;
        logic ctrl_src;          // 0 rd1, 1 rs1 field
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [xlen-1:0] imm_ext;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0] ctrl_data;
        logic [n_ctrl_regs-1:0] status;
    } decode_t;

endpackage
